// ==== hw/branch_defines.svh ====
//==========================================================
// Widths and BTB geometry for the RV64I branch unit.
// BTB_ENTRIES must equal 2**BTB_IDX_W. The index comes from
// pc bits BTB_IDX_W+1 down to 2, so pcs are 4-byte aligned.
//==========================================================

`ifndef BRANCH_DEFINES_SVH
`define BRANCH_DEFINES_SVH

// Instruction address width.
`define ADDR_W 64

// Register operand width.
`define DATA_W 64

// BTB index bits, taken above the two byte-offset bits.
`define BTB_IDX_W 4

// Number of BTB entries.
`define BTB_ENTRIES 16

`endif

// ==== hw/branch_pkg.sv ====
//==========================================================
// Types shared by the branch unit modules.
// Widths follow branch_defines.svh.
//==========================================================

`default_nettype none

`include "branch_defines.svh"

package branch_pkg;

	typedef logic [`ADDR_W-1:0] addr_t;
	typedef logic [`DATA_W-1:0] data_t;
	typedef logic [31:0] instr_t;
	typedef logic [`BTB_IDX_W-1:0] btb_idx_t;
	typedef logic [`ADDR_W-`BTB_IDX_W-3:0] btb_tag_t; // Pc bits above the index.

	typedef enum logic [3:0] {
		jmp_none = 4'd0,
		jmp_beq  = 4'd1,
		jmp_bne  = 4'd2,
		jmp_blt  = 4'd3,
		jmp_bge  = 4'd4,
		jmp_bltu = 4'd5,
		jmp_bgeu = 4'd6,
		jmp_jal  = 4'd7,
		jmp_jalr = 4'd8
	} jmp_kind_t;

	// hold_ex freezes fetch through execute.
	typedef enum logic {
		hold_none = 1'b0,
		hold_ex   = 1'b1
	} hold_code_t;

	typedef struct packed {
		jmp_kind_t kind;
		logic      base_rs1; // Base is rs1, else pc.
		addr_t     imm;      // Sign-extended offset.
	} jmp_dec_t;

	typedef struct packed {
		logic     valid;
		btb_tag_t tag;
		addr_t    target;
	} btb_entry_t;

endpackage

`default_nettype wire

// ==== hw/jump_decode.sv ====
//==========================================================
// Jump decoder for branch, jal and jalr.
// jalr needs funct3 000, branches with funct3 010 or 011
// and every other opcode decode to jmp_none.
//==========================================================

`timescale 1ns/100ps
`default_nettype none

module jump_decode
	import branch_pkg::*;
(
	input  instr_t   instr_i,
	output jmp_dec_t dec_o
);

	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;

	logic [6:0]         opcode;
	logic [2:0]         funct3;
	logic signed [12:0] imm_b;
	logic signed [20:0] imm_j;
	logic signed [11:0] imm_i;
	jmp_kind_t          kind;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];

	assign imm_b = {instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_j = {instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
	assign imm_i = instr_i[31:20];

	always_comb begin
		kind = jmp_none;
		case (opcode)
			opc_branch: begin
				case (funct3)
					3'b000: kind = jmp_beq;
					3'b001: kind = jmp_bne;
					3'b100: kind = jmp_blt;
					3'b101: kind = jmp_bge;
					3'b110: kind = jmp_bltu;
					3'b111: kind = jmp_bgeu;
					default: kind = jmp_none; // Reserved encodings.
				endcase
			end
			opc_jal: kind = jmp_jal;
			opc_jalr: begin
				if (funct3 == 3'b000) begin
					kind = jmp_jalr;
				end
			end
			default: kind = jmp_none;
		endcase
	end

	// Signed casts sign-extend the offsets to the address width.
	always_comb begin
		dec_o.kind     = kind;
		dec_o.base_rs1 = (kind == jmp_jalr);
		case (kind)
			jmp_none: dec_o.imm = '0;
			jmp_jal:  dec_o.imm = addr_t'(imm_j);
			jmp_jalr: dec_o.imm = addr_t'(imm_i);
			default:  dec_o.imm = addr_t'(imm_b); // B-type.
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/branch_resolve.sv ====
//==========================================================
// Execute-stage branch resolution.
// Purely combinational. The jalr target has bit 0 cleared;
// no misalignment check is made on any target.
//==========================================================

`timescale 1ns/100ps
`default_nettype none

module branch_resolve
	import branch_pkg::*;
(
	input  jmp_dec_t dec_i,
	input  addr_t    pc_i,
	input  data_t    rs1_i,
	input  data_t    rs2_i,
	output logic     taken_o,
	output addr_t    target_o
);

	logic  rs_eq;
	logic  rs_lt_s;
	logic  rs_lt_u;
	addr_t base;
	addr_t sum;

	// Shared comparators for all six conditions.
	assign rs_eq   = (rs1_i == rs2_i);
	assign rs_lt_s = ($signed(rs1_i) < $signed(rs2_i));
	assign rs_lt_u = (rs1_i < rs2_i);

	always_comb begin
		case (dec_i.kind)
			jmp_beq:  taken_o = rs_eq;
			jmp_bne:  taken_o = !rs_eq;
			jmp_blt:  taken_o = rs_lt_s;
			jmp_bge:  taken_o = !rs_lt_s;
			jmp_bltu: taken_o = rs_lt_u;
			jmp_bgeu: taken_o = !rs_lt_u;
			jmp_jal, jmp_jalr: taken_o = 1'b1; // Unconditional.
			default:  taken_o = 1'b0;
		endcase
	end

	assign base = dec_i.base_rs1 ? addr_t'(rs1_i) : pc_i;
	assign sum  = base + dec_i.imm;

	assign target_o = (dec_i.kind == jmp_jalr) ? (sum & ~addr_t'(1)) : sum;

endmodule

`default_nettype wire

// ==== hw/btb.sv ====
//==========================================================
// Direct-mapped branch target buffer.
// Two combinational lookups and one write port; an update
// is visible at the next rising clk edge. Entries hold
// taken jumps only; a hit means "predict taken".
//==========================================================

`timescale 1ns/100ps
`default_nettype none

`include "branch_defines.svh"

module btb
	import branch_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n_i,
	input  logic  upd_en_i,
	input  addr_t pc_pred_i,
	input  addr_t pc_instr_i,
	input  logic  taken_i,
	input  addr_t target_i,
	output logic  pred_hit_o,
	output addr_t pred_target_o,
	output logic  mispredict_o
);

	btb_entry_t entries [`BTB_ENTRIES];

	btb_idx_t   pred_idx;
	btb_tag_t   pred_tag;
	btb_entry_t pred_ent;
	btb_idx_t   ex_idx;
	btb_tag_t   ex_tag;
	btb_entry_t ex_ent;
	logic       ex_hit;

	assign pred_idx = pc_pred_i[`BTB_IDX_W+1:2];
	assign pred_tag = pc_pred_i[`ADDR_W-1:`BTB_IDX_W+2];
	assign ex_idx   = pc_instr_i[`BTB_IDX_W+1:2];
	assign ex_tag   = pc_instr_i[`ADDR_W-1:`BTB_IDX_W+2];

	// Fetch-side lookup.
	assign pred_ent      = entries[pred_idx];
	assign pred_hit_o    = pred_ent.valid && (pred_ent.tag == pred_tag);
	assign pred_target_o = pred_ent.target;

	// What fetch predicted when this instruction went by.
	assign ex_ent = entries[ex_idx];
	assign ex_hit = ex_ent.valid && (ex_ent.tag == ex_tag);

	assign mispredict_o = (ex_hit != taken_i) ||
	                      (ex_hit && taken_i && (ex_ent.target != target_i));

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `BTB_ENTRIES; i++) begin
				entries[i] <= '0;
			end
		end else if (upd_en_i) begin
			if (taken_i) begin
				entries[ex_idx] <= '{valid: 1'b1, tag: ex_tag, target: target_i};
			end else if (ex_hit) begin
				entries[ex_idx].valid <= 1'b0; // Drop stale prediction.
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/redirect_ctrl.sv ====
//==========================================================
// Result stage of the branch unit.
// Redirect priority is irq, then BTB prediction, then the
// forced fix-up. Any stall freezes the BTB and the mask.
//==========================================================

`timescale 1ns/100ps
`default_nettype none

module redirect_ctrl
	import branch_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n_i,
	input  logic       stall_if_i,
	input  logic       stall_mem_i,
	input  logic       irq_i,
	input  addr_t      irq_to_i,
	input  logic       is_jump_i,
	input  logic       load_bypass_i,
	input  logic       taken_i,
	input  addr_t      target_i,
	input  addr_t      pc_instr_i,
	input  logic       pred_hit_i,
	input  addr_t      pred_target_i,
	input  logic       mispredict_i,
	output logic       eff_taken_o,
	output logic       upd_en_o,
	output logic       jmp_en_o,
	output addr_t      jmp_to_o,
	output logic       instr_mask_o,
	output hold_code_t hold_code_o
);

	logic mask_q;

	// Load bypass cancels the resolved jump.
	assign eff_taken_o = taken_i && !load_bypass_i;

	assign hold_code_o = (stall_if_i || stall_mem_i) ? hold_ex : hold_none;
	assign upd_en_o    = (hold_code_o == hold_none) && is_jump_i;

	always_comb begin
		if (irq_i) begin
			jmp_en_o = 1'b1;
			jmp_to_o = irq_to_i;
		end else if (!mispredict_i) begin
			jmp_en_o = pred_hit_i; // Prediction was right.
			jmp_to_o = pred_target_i;
		end else begin
			jmp_en_o = 1'b1;
			jmp_to_o = eff_taken_o ? target_i : pc_instr_i + addr_t'(4);
		end
	end

	// Squashes the wrong-path instruction one cycle later.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mask_q <= 1'b0;
		end else if (hold_code_o == hold_none) begin
			mask_q <= mispredict_i;
		end
	end

	assign instr_mask_o = mask_q;

endmodule

`default_nettype wire

// ==== hw/branch_unit.sv ====
//==========================================================
// Branch resolution and prediction block, execute stage.
// Fetch, register file and CSR logic live outside; irq_i
// and the stall inputs must be valid in the same cycle.
//==========================================================

`timescale 1ns/100ps
`default_nettype none

module branch_unit
	import branch_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n_i,
	input  instr_t     instr_i,
	input  addr_t      pc_instr_i,
	input  addr_t      pc_pred_i,
	input  data_t      rs1_i,
	input  data_t      rs2_i,
	input  logic       load_bypass_i,
	input  logic       stall_if_i,
	input  logic       stall_mem_i,
	input  logic       irq_i,
	input  addr_t      irq_to_i,
	output logic       jmp_en_o,
	output addr_t      jmp_to_o,
	output logic       instr_mask_o,
	output hold_code_t hold_code_o
);

	jmp_dec_t dec;
	logic     is_jump;
	logic     taken;
	addr_t    target;
	logic     eff_taken;
	logic     upd_en;
	logic     pred_hit;
	addr_t    pred_target;
	logic     mispredict;

	assign is_jump = (dec.kind != jmp_none);

	jump_decode u_decode (
		.instr_i (instr_i),
		.dec_o   (dec)
	);

	branch_resolve u_resolve (
		.dec_i    (dec),
		.pc_i     (pc_instr_i),
		.rs1_i    (rs1_i),
		.rs2_i    (rs2_i),
		.taken_o  (taken),
		.target_o (target)
	);

	btb u_btb (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.upd_en_i      (upd_en),
		.pc_pred_i     (pc_pred_i),
		.pc_instr_i    (pc_instr_i),
		.taken_i       (eff_taken),
		.target_i      (target),
		.pred_hit_o    (pred_hit),
		.pred_target_o (pred_target),
		.mispredict_o  (mispredict)
	);

	redirect_ctrl u_redirect (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.stall_if_i    (stall_if_i),
		.stall_mem_i   (stall_mem_i),
		.irq_i         (irq_i),
		.irq_to_i      (irq_to_i),
		.is_jump_i     (is_jump),
		.load_bypass_i (load_bypass_i),
		.taken_i       (taken),
		.target_i      (target),
		.pc_instr_i    (pc_instr_i),
		.pred_hit_i    (pred_hit),
		.pred_target_i (pred_target),
		.mispredict_i  (mispredict),
		.eff_taken_o   (eff_taken),
		.upd_en_o      (upd_en),
		.jmp_en_o      (jmp_en_o),
		.jmp_to_o      (jmp_to_o),
		.instr_mask_o  (instr_mask_o),
		.hold_code_o   (hold_code_o)
	);

endmodule

`default_nettype wire

// ==== test/branch_checker.sv ====
//============================================================
// Concurrent rules on branch_unit outputs, attached by bind.
// Sampled at the rising clk edge and off during reset.
//============================================================

`timescale 1ns/100ps
`default_nettype none

module branch_checker
	import branch_pkg::*;
(
	input logic       clk,
	input logic       arst_n_i,
	input logic       stall_if_i,
	input logic       stall_mem_i,
	input logic       irq_i,
	input logic       jmp_en_o,
	input logic       instr_mask_o,
	input hold_code_t hold_code_o
);

	int n_fail = 0;

	// A held cycle leaves the mask register alone.
	mask_held: assert property (@(posedge clk) disable iff (!arst_n_i)
		(hold_code_o == hold_ex) |=> $stable(instr_mask_o))
		else begin
			n_fail++;
			$error("instr_mask_o changed across a held cycle");
		end

	hold_from_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
		(hold_code_o == hold_ex) == (stall_if_i || stall_mem_i))
		else begin
			n_fail++;
			$error("hold_code_o does not follow the stall inputs");
		end

	irq_redirects: assert property (@(posedge clk) disable iff (!arst_n_i)
		irq_i |-> jmp_en_o)
		else begin
			n_fail++;
			$error("irq_i set without jmp_en_o");
		end

endmodule

bind branch_unit branch_checker u_checker (
	.clk          (clk),
	.arst_n_i     (arst_n_i),
	.stall_if_i   (stall_if_i),
	.stall_mem_i  (stall_mem_i),
	.irq_i        (irq_i),
	.jmp_en_o     (jmp_en_o),
	.instr_mask_o (instr_mask_o),
	.hold_code_o  (hold_code_o)
);

`default_nettype wire

// ==== test/tb_branch_unit.sv ====
//============================================================
// Random-stimulus testbench for branch_unit.
// A model BTB and mask register track the DUT. Outputs are
// compared at the falling edge, when all inputs are settled.
//============================================================

`timescale 1ns/100ps
`default_nettype none

`include "branch_defines.svh"

module tb_branch_unit
	import branch_pkg::*;
();

	localparam int NUM_CYCLES = 600;

	typedef struct packed {
		logic  is_jump;
		logic  taken;      // After the bypass cancel.
		addr_t target;
		logic  ex_hit;
		logic  mispredict;
		logic  jmp_en;
		addr_t jmp_to;
	} expect_t;

	logic       clk;
	logic       arst_n_i      = 1'b0;
	instr_t     instr_i       = '0;
	addr_t      pc_instr_i    = '0;
	addr_t      pc_pred_i     = '0;
	data_t      rs1_i         = '0;
	data_t      rs2_i         = '0;
	logic       load_bypass_i = 1'b0;
	logic       stall_if_i    = 1'b0;
	logic       stall_mem_i   = 1'b0;
	logic       irq_i         = 1'b0;
	addr_t      irq_to_i      = '0;
	logic       jmp_en_o;
	addr_t      jmp_to_o;
	logic       instr_mask_o;
	hold_code_t hold_code_o;

	logic [31:0] lfsr     = 32'h736b;
	int          cycle    = 0;
	int          n_cmp    = 0;
	int          n_checks = 0;
	int          n_errors = 0;

	logic     m_valid  [`BTB_ENTRIES];
	btb_tag_t m_tag    [`BTB_ENTRIES];
	addr_t    m_target [`BTB_ENTRIES];
	logic     m_mask;

	branch_unit u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Galois LFSR, one step per bit taken.
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// Borderline operands for signed and unsigned compares.
	function automatic data_t edge_value(input logic [2:0] k);
		case (k)
			3'd0: return 64'h0000_0000_0000_0000;
			3'd1: return 64'h0000_0000_0000_0001;
			3'd2: return 64'h7fff_ffff_ffff_ffff;
			3'd3: return 64'h8000_0000_0000_0000;
			3'd4: return 64'hffff_ffff_ffff_ffff;
			3'd5: return 64'h8000_0000_0000_0001;
			3'd6: return 64'hffff_ffff_ffff_fffe;
			default: return 64'h7fff_ffff_ffff_fffe;
		endcase
	endfunction

	// Small pool so BTB hits and index aliasing occur.
	function automatic addr_t pool_pc(input logic [2:0] k);
		case (k)
			3'd0: return 64'h0000_0000_0000_1000;
			3'd1: return 64'h0000_0000_0000_1004;
			3'd2: return 64'h0000_0000_0000_1040; // Same index as 0x1000.
			3'd3: return 64'h0000_0000_0000_2008;
			3'd4: return 64'h8000_0000_0000_100c;
			3'd5: return 64'hffff_ffff_ffff_fff0;
			3'd6: return 64'h0000_0000_0000_1044;
			default: return 64'h0000_0000_0000_103c;
		endcase
	endfunction

	function automatic expect_t ref_outcome(input instr_t w, input addr_t pc,
			input addr_t pc_pred, input data_t a, input data_t b,
			input logic bypass, input logic irq, input addr_t irq_to);
		logic [63:0] imm_b;
		logic [63:0] imm_j;
		logic [63:0] imm_i;
		logic [63:0] sgn;
		logic        cond;
		logic        pred_hit;
		btb_idx_t    ei;
		btb_idx_t    pi;
		expect_t     e;
		imm_b = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		imm_j = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		imm_i = {{52{w[31]}}, w[31:20]};
		sgn = 64'h8000_0000_0000_0000;
		e = '0;
		cond = 1'b0;
		if (w[6:0] == 7'h63) begin
			e.is_jump = 1'b1;
			case (w[14:12])
				3'd0: cond = (a == b);
				3'd1: cond = (a != b);
				3'd4: cond = ((a ^ sgn) < (b ^ sgn)); // Signed order, sign bit flipped.
				3'd5: cond = ((a ^ sgn) >= (b ^ sgn));
				3'd6: cond = (a < b);
				3'd7: cond = (a >= b);
				default: e.is_jump = 1'b0;
			endcase
			e.target = pc + imm_b;
		end else if (w[6:0] == 7'h6f) begin
			e.is_jump = 1'b1;
			cond = 1'b1;
			e.target = pc + imm_j;
		end else if (w[6:0] == 7'h67 && w[14:12] == 3'd0) begin
			e.is_jump = 1'b1;
			cond = 1'b1;
			e.target = (a + imm_i) & ~64'd1;
		end
		e.taken = cond && !bypass;
		ei = pc[`BTB_IDX_W+1:2];
		pi = pc_pred[`BTB_IDX_W+1:2];
		e.ex_hit = m_valid[ei] && (m_tag[ei] == pc[`ADDR_W-1:`BTB_IDX_W+2]);
		pred_hit = m_valid[pi] && (m_tag[pi] == pc_pred[`ADDR_W-1:`BTB_IDX_W+2]);
		e.mispredict = (e.ex_hit != e.taken) ||
		               (e.ex_hit && e.taken && (m_target[ei] != e.target));
		if (irq) begin
			e.jmp_en = 1'b1;
			e.jmp_to = irq_to;
		end else if (!e.mispredict) begin
			e.jmp_en = pred_hit;
			e.jmp_to = m_target[pi];
		end else begin
			e.jmp_en = 1'b1;
			e.jmp_to = e.taken ? e.target : pc + 64'd4;
		end
		return e;
	endfunction

	task automatic drive_random();
		instr_t     w;
		logic [2:0] op;
		logic [1:0] rs_mode;
		data_t      a;
		data_t      b;
		w = 32'(rand_bits(32));
		op = 3'(rand_bits(3));
		case (op)
			3'd4: w[6:0] = 7'h6f;
			3'd5: begin
				w[6:0] = 7'h67;
				w[14:12] = 3'd0;
			end
			3'd6: w[6:0] = 7'h13; // addi
			3'd7: w[6:0] = 7'h67; // Mostly bad funct3.
			default: w[6:0] = 7'h63;
		endcase
		rs_mode = 2'(rand_bits(2));
		a = rand_bits(64);
		b = rand_bits(64);
		if (rs_mode == 2'd0) begin
			b = a;
		end else if (rs_mode == 2'd1) begin
			a = edge_value(3'(rand_bits(3)));
			b = edge_value(3'(rand_bits(3)));
		end
		instr_i       <= w;
		pc_instr_i    <= pool_pc(3'(rand_bits(3)));
		pc_pred_i     <= pool_pc(3'(rand_bits(3)));
		rs1_i         <= a;
		rs2_i         <= b;
		load_bypass_i <= (3'(rand_bits(3)) == 3'd0);
		stall_if_i    <= (3'(rand_bits(3)) == 3'd0);
		stall_mem_i   <= (3'(rand_bits(3)) == 3'd0);
		irq_i         <= (4'(rand_bits(4)) == 4'd0);
		irq_to_i      <= rand_bits(64) & ~64'd3;
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle == 2) begin
			arst_n_i <= 1'b1;
		end else if (cycle > 2) begin
			drive_random();
		end
	end

	// Model state moves here, standing for the next rising edge.
	always @(negedge clk) begin
		expect_t  e;
		btb_idx_t idx;
		logic     held;
		if (!arst_n_i) begin
			for (int i = 0; i < `BTB_ENTRIES; i++) begin
				m_valid[i] = 1'b0;
				m_tag[i] = '0;
				m_target[i] = '0;
			end
			m_mask = 1'b0;
		end else begin
			e = ref_outcome(instr_i, pc_instr_i, pc_pred_i, rs1_i, rs2_i,
			                load_bypass_i, irq_i, irq_to_i);
			held = stall_if_i || stall_mem_i;
			n_cmp++;
			n_checks += e.jmp_en ? 4 : 3;
			if (hold_code_o != (held ? hold_ex : hold_none)) begin
				$display("FAILED at %0t: hold_code_o %0d, stalls %b %b", $time,
				         hold_code_o, stall_if_i, stall_mem_i);
				n_errors++;
			end
			if (instr_mask_o != m_mask) begin
				$display("FAILED at %0t: instr_mask_o %b, expected %b", $time,
				         instr_mask_o, m_mask);
				n_errors++;
			end
			if (jmp_en_o != e.jmp_en) begin
				$display("FAILED at %0t: jmp_en_o %b, expected %b", $time, jmp_en_o, e.jmp_en);
				n_errors++;
			end
			if (e.jmp_en && jmp_to_o != e.jmp_to) begin
				$display("FAILED at %0t: jmp_to_o %h, expected %h", $time, jmp_to_o, e.jmp_to);
				n_errors++;
			end
			if (!held) begin
				m_mask = e.mispredict;
				idx = pc_instr_i[`BTB_IDX_W+1:2];
				if (e.is_jump && e.taken) begin
					m_valid[idx] = 1'b1;
					m_tag[idx] = pc_instr_i[`ADDR_W-1:`BTB_IDX_W+2];
					m_target[idx] = e.target;
				end else if (e.is_jump && e.ex_hit) begin
					m_valid[idx] = 1'b0;
				end
			end
		end
	end

	initial begin
		int guard;
		guard = 0;
		while (n_cmp < NUM_CYCLES && guard < NUM_CYCLES + 50) begin
			@(posedge clk);
			guard++;
		end
		if (n_cmp < NUM_CYCLES) begin
			$display("Timeout: only %0d of %0d cycles were compared", n_cmp, NUM_CYCLES);
			$display("Checks failed");
			$finish;
		end else begin
			$display("Compared %0d cycles, %0d checks, %0d errors, %0d assertion failures",
			         n_cmp, n_checks, n_errors, u_dut.u_checker.n_fail);
			if (n_errors == 0 && u_dut.u_checker.n_fail == 0) begin
				$display("All checks passed");
			end else begin
				$display("Checks failed");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hw
hw/branch_pkg.sv
hw/jump_decode.sv
hw/branch_resolve.sv
hw/btb.sv
hw/redirect_ctrl.sv
hw/branch_unit.sv
test/branch_checker.sv
test/tb_branch_unit.sv

// ==== Makefile ====
# Verilator build and run of the branch unit testbench.

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tb_branch_unit with Verilator and run it"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -f tb.f --top-module tb_branch_unit -o Vtb_branch_unit
	./obj_dir/Vtb_branch_unit +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG) || ! grep -q "All checks passed" $(LOG); then \
		echo "Simulation FAILED"; \
		exit 1; \
	else \
		echo "Simulation OK"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
